// ==== hw/lstm_activation.sv ====
`include "lstm_config.svh"

module lstm_activation (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 pre_vld_i,
  input  lstm_pkg::unit_idx_t  pre_unit_i,
  input  lstm_pkg::preact_t    pre_i_i,
  input  lstm_pkg::preact_t    pre_f_i,
  input  lstm_pkg::preact_t    pre_c_i,
  input  lstm_pkg::preact_t    pre_o_i,
  output logic                 act_vld_o,
  output lstm_pkg::unit_idx_t  act_unit_o,
  output lstm_pkg::sample_t    gate_i_o,
  output lstm_pkg::sample_t    gate_f_o,
  output lstm_pkg::sample_t    gate_g_o,
  output lstm_pkg::sample_t    gate_o_o
);

  localparam int ONE = `LSTM_ONE;

  // x/4 + 0.5, clamped to 0..1
  function automatic lstm_pkg::sample_t hard_sigmoid(input lstm_pkg::preact_t x);
    logic signed [31:0] t;
    t = (x >>> 2) + ONE / 2;
    if (t < 0)
      return '0;
    else if (t > ONE)
      return lstm_pkg::sample_t'(ONE);
    else
      return t[15:0];
  endfunction

  // clamp to -1..1
  function automatic lstm_pkg::sample_t hard_tanh(input lstm_pkg::preact_t x);
    if (x > ONE)
      return lstm_pkg::sample_t'(ONE);
    else if (x < -ONE)
      return lstm_pkg::sample_t'(-ONE);
    else
      return x[15:0];
  endfunction

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      act_vld_o <= 1'b0;
    else
      act_vld_o <= pre_vld_i;
  end

  // payload follows the valid by one cycle
  always_ff @(posedge clk)
  begin
    act_unit_o <= pre_unit_i;
    gate_i_o   <= hard_sigmoid(pre_i_i);
    gate_f_o   <= hard_sigmoid(pre_f_i);
    gate_g_o   <= hard_tanh(pre_c_i);   // candidate
    gate_o_o   <= hard_sigmoid(pre_o_i);
  end

endmodule

// ==== hw/lstm_cell_top.sv ====
`include "lstm_config.svh"

module lstm_cell_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      cfg_we_i,
  input  logic [`LSTM_ADDR_W-1:0]   cfg_addr_i,
  input  lstm_pkg::gate_row_t       cfg_wdata_i,
  input  logic                      clear_state_i,
  input  logic                      din_vld_i,
  input  lstm_pkg::sample_t         din_i,
  output logic                      dout_vld_o,
  output lstm_pkg::unit_idx_t       dout_idx_o,
  output lstm_pkg::sample_t         dout_o,
  output logic                      busy_o
);

  // sequencer to mac and weight bank
  logic                      term_vld, term_first, term_last;
  lstm_pkg::sample_t         operand;
  logic [`LSTM_ADDR_W-1:0]   w_addr;
  lstm_pkg::unit_idx_t       term_unit;
  lstm_pkg::gate_row_t       w_row, b_row;
  lstm_pkg::unit_idx_t       b_unit;

  // mac to activation
  logic                      pre_vld;
  lstm_pkg::unit_idx_t       pre_unit;
  lstm_pkg::preact_t         pre_i, pre_f, pre_c, pre_o;

  // activation to state update
  logic                      act_vld;
  lstm_pkg::unit_idx_t       act_unit;
  lstm_pkg::sample_t         gate_i, gate_f, gate_g, gate_o;

  // state update back to sequencer
  lstm_pkg::sample_t         h_prev [`LSTM_HID_DIM];
  logic                      commit;

  lstm_weight_bank u_bank (
    .clk, .rst_n, .cfg_we_i, .cfg_addr_i, .cfg_wdata_i,
    .w_addr_i (w_addr), .b_unit_i (b_unit), .w_row_o (w_row), .b_row_o (b_row)
  );

  lstm_sequencer u_seq (
    .clk, .rst_n, .din_vld_i, .din_i, .h_prev_i (h_prev), .commit_i (commit), .busy_o,
    .term_vld_o (term_vld), .term_first_o (term_first), .term_last_o (term_last),
    .operand_o (operand), .w_addr_o (w_addr), .unit_o (term_unit)
  );

  lstm_gate_mac u_mac (
    .clk, .rst_n, .term_vld_i (term_vld), .term_first_i (term_first),
    .term_last_i (term_last), .operand_i (operand), .w_row_i (w_row), .b_row_i (b_row),
    .unit_i (term_unit), .b_unit_o (b_unit), .pre_vld_o (pre_vld), .pre_unit_o (pre_unit),
    .pre_i_o (pre_i), .pre_f_o (pre_f), .pre_c_o (pre_c), .pre_o_o (pre_o)
  );

  lstm_activation u_act (
    .clk, .rst_n, .pre_vld_i (pre_vld), .pre_unit_i (pre_unit),
    .pre_i_i (pre_i), .pre_f_i (pre_f), .pre_c_i (pre_c), .pre_o_i (pre_o),
    .act_vld_o (act_vld), .act_unit_o (act_unit),
    .gate_i_o (gate_i), .gate_f_o (gate_f), .gate_g_o (gate_g), .gate_o_o (gate_o)
  );

  lstm_state_update u_state (
    .clk, .rst_n, .clear_state_i, .act_vld_i (act_vld), .act_unit_i (act_unit),
    .gate_i_i (gate_i), .gate_f_i (gate_f), .gate_g_i (gate_g), .gate_o_i (gate_o),
    .h_prev_o (h_prev), .commit_o (commit), .dout_vld_o, .dout_idx_o, .dout_o
  );

endmodule

// ==== hw/lstm_config.svh ====
`ifndef LSTM_CONFIG_SVH
`define LSTM_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// cell dimensions
//////////////////////////////////////////////////////////////////////

`define LSTM_IN_DIM     4   // x samples per step
`define LSTM_HID_DIM    4   // hidden units
`define LSTM_TERMS      8   // in + hid terms per dot product

// weight rows then one bias row per unit
`define LSTM_ROWS       36
`define LSTM_ADDR_W     6

//////////////////////////////////////////////////////////////////////
// fixed point formats
//////////////////////////////////////////////////////////////////////

`define LSTM_DATA_FRAC  12  // Q3.12 samples
`define LSTM_W_FRAC     13  // Q2.13 weights
`define LSTM_ONE        4096

`endif

// ==== hw/lstm_gate_mac.sv ====
`include "lstm_config.svh"

module lstm_gate_mac (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 term_vld_i,
  input  logic                 term_first_i,
  input  logic                 term_last_i,
  input  lstm_pkg::sample_t    operand_i,
  input  lstm_pkg::gate_row_t  w_row_i,
  input  lstm_pkg::gate_row_t  b_row_i,
  input  lstm_pkg::unit_idx_t  unit_i,
  output lstm_pkg::unit_idx_t  b_unit_o,
  output logic                 pre_vld_o,
  output lstm_pkg::unit_idx_t  pre_unit_o,
  output lstm_pkg::preact_t    pre_i_o,
  output lstm_pkg::preact_t    pre_f_o,
  output lstm_pkg::preact_t    pre_c_o,
  output lstm_pkg::preact_t    pre_o_o
);

  localparam int GW     = 16;                    // field width in a gate row
  localparam int ACC_W  = 32;
  localparam int W_FRAC = `LSTM_W_FRAC;
  localparam int SH_W   = ACC_W - W_FRAC;        // sum after the shift
  localparam int PMAX   = (1 << 17) - 1;         // preact_t limits
  localparam int PMIN   = -(1 << 17);

  logic                vld_d, first_d, last_d;   // aligned to product stage
  lstm_pkg::unit_idx_t unit_d;
  lstm_pkg::weight_t   w_s     [4];
  lstm_pkg::sample_t   bias_s  [4];
  lstm_pkg::acc_t      prod_q  [4];
  lstm_pkg::acc_t      acc_q   [4];
  lstm_pkg::acc_t      acc_nx  [4];
  logic signed [SH_W-1:0] acc_sh  [4];
  logic signed [SH_W:0]   pre_sum [4];
  lstm_pkg::preact_t   pre_q   [4];

  // clamp to 18 bit signed range
  function automatic lstm_pkg::preact_t sat_pre(input logic signed [SH_W:0] v);
    if (v > PMAX)
      return lstm_pkg::preact_t'(PMAX);
    else if (v < PMIN)
      return lstm_pkg::preact_t'(PMIN);
    else
      return v[17:0];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // per gate field split, accumulate and bias add
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int g = 0; g < 4; g++)
    begin
      w_s[g]    = w_row_i[GW*(3-g) +: GW];   // g=0 is i at the top
      bias_s[g] = b_row_i[GW*(3-g) +: GW];
      acc_nx[g] = first_d ? prod_q[g] : acc_q[g] + prod_q[g];  // first term loads
      acc_sh[g] = acc_nx[g][ACC_W-1:W_FRAC];  // >>> 13, back to 12 frac bits
      pre_sum[g] = (SH_W+1)'(acc_sh[g]) + (SH_W+1)'(bias_s[g]);
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      vld_d     <= 1'b0;
      first_d   <= 1'b0;
      last_d    <= 1'b0;
      unit_d    <= '0;
      pre_vld_o <= 1'b0;
    end
    else
    begin
      vld_d     <= term_vld_i;
      first_d   <= term_first_i;
      last_d    <= term_last_i;
      unit_d    <= unit_i;
      pre_vld_o <= vld_d && last_d;  // 2 cycles after the last term
    end
  end

  always_ff @(posedge clk)
  begin
    for (int g = 0; g < 4; g++)
    begin
      prod_q[g] <= operand_i * w_s[g];  // registered multiplier
      if (vld_d)
      begin
        acc_q[g] <= acc_nx[g];
      end
      if (vld_d && last_d)
      begin
        pre_q[g] <= sat_pre(pre_sum[g]);
      end
    end
    if (vld_d && last_d)
    begin
      pre_unit_o <= unit_d;
    end
  end

  assign b_unit_o = unit_d;  // bias read tracks the closing unit

  assign pre_i_o = pre_q[0];
  assign pre_f_o = pre_q[1];
  assign pre_c_o = pre_q[2];
  assign pre_o_o = pre_q[3];

endmodule

// ==== hw/lstm_pkg.sv ====
`include "lstm_config.svh"

package lstm_pkg;

  // Q3.12 data word: x, h, c, bias and gate outputs
  typedef logic signed [15:0] sample_t;

  // Q2.13 kernel word
  typedef logic signed [15:0] weight_t;

  // sample times weight, 25 fraction bits, wraps mod 2^32
  typedef logic signed [31:0] acc_t;

  // saturated pre-activation, Q5.12
  typedef logic signed [17:0] preact_t;

  // four 16 bit fields, i f c o from the msb down
  typedef logic [63:0] gate_row_t;

  typedef logic [$clog2(`LSTM_HID_DIM)-1:0] unit_idx_t;  // hidden unit
  typedef logic [$clog2(`LSTM_TERMS)-1:0]   term_idx_t;  // dot product term

endpackage

// ==== hw/lstm_sequencer.sv ====
`include "lstm_config.svh"

module lstm_sequencer (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      din_vld_i,
  input  lstm_pkg::sample_t         din_i,
  input  lstm_pkg::sample_t         h_prev_i [`LSTM_HID_DIM],
  input  logic                      commit_i,
  output logic                      busy_o,
  output logic                      term_vld_o,
  output logic                      term_first_o,
  output logic                      term_last_o,
  output lstm_pkg::sample_t         operand_o,
  output logic [`LSTM_ADDR_W-1:0]   w_addr_o,
  output lstm_pkg::unit_idx_t       unit_o
);

  localparam int IN_W = $clog2(`LSTM_IN_DIM);
  localparam int AW   = `LSTM_ADDR_W;

  lstm_pkg::sample_t   x_q [`LSTM_IN_DIM];  // current input vector
  logic [IN_W-1:0]     x_cnt;               // samples captured so far
  logic                run_q;               // terms being issued
  lstm_pkg::term_idx_t term_cnt;
  lstm_pkg::unit_idx_t unit_cnt;
  logic [IN_W-1:0]     x_sel;
  lstm_pkg::unit_idx_t h_sel;
  logic                cap;

  assign cap = din_vld_i && !busy_o;  // no capture mid step

  //////////////////////////////////////////////////////////////////////
  // input capture
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (cap)
    begin
      x_q[x_cnt] <= din_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // step control, unit and term counters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      x_cnt    <= '0;
      busy_o   <= 1'b0;
      run_q    <= 1'b0;
      term_cnt <= '0;
      unit_cnt <= '0;
    end
    else
    begin
      if (cap)
      begin
        x_cnt <= x_cnt + 1'b1;  // wraps back to 0 after last sample
        if (x_cnt == IN_W'(`LSTM_IN_DIM - 1))
        begin
          busy_o <= 1'b1;  // high from the next cycle
          run_q  <= 1'b1;
        end
      end

      if (run_q)
      begin
        if (term_cnt == lstm_pkg::term_idx_t'(`LSTM_TERMS - 1))
        begin
          term_cnt <= '0;
          unit_cnt <= unit_cnt + 1'b1;  // next unit, no bubble
          if (unit_cnt == lstm_pkg::unit_idx_t'(`LSTM_HID_DIM - 1))
          begin
            run_q <= 1'b0;  // 32 terms issued
          end
        end
        else
        begin
          term_cnt <= term_cnt + 1'b1;
        end
      end

      // pipeline drained and new h in place
      if (commit_i)
      begin
        busy_o <= 1'b0;
      end
    end
  end

  // terms 0..3 are x, terms 4..7 are previous h
  assign x_sel = term_cnt[IN_W-1:0];
  assign h_sel = lstm_pkg::unit_idx_t'(term_cnt - lstm_pkg::term_idx_t'(`LSTM_IN_DIM));

  assign operand_o = (term_cnt < lstm_pkg::term_idx_t'(`LSTM_IN_DIM)) ? x_q[x_sel]
                                                                     : h_prev_i[h_sel];

  // row j*8+k
  assign w_addr_o = AW'(unit_cnt) * AW'(`LSTM_TERMS) + AW'(term_cnt);

  assign term_vld_o   = run_q;
  assign term_first_o = run_q && (term_cnt == '0);
  assign term_last_o  = run_q && (term_cnt == lstm_pkg::term_idx_t'(`LSTM_TERMS - 1));
  assign unit_o       = unit_cnt;

endmodule

// ==== hw/lstm_state_update.sv ====
`include "lstm_config.svh"

module lstm_state_update (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 clear_state_i,
  input  logic                 act_vld_i,
  input  lstm_pkg::unit_idx_t  act_unit_i,
  input  lstm_pkg::sample_t    gate_i_i,
  input  lstm_pkg::sample_t    gate_f_i,
  input  lstm_pkg::sample_t    gate_g_i,
  input  lstm_pkg::sample_t    gate_o_i,
  output lstm_pkg::sample_t    h_prev_o [`LSTM_HID_DIM],
  output logic                 commit_o,
  output logic                 dout_vld_o,
  output lstm_pkg::unit_idx_t  dout_idx_o,
  output lstm_pkg::sample_t    dout_o
);

  localparam int HID  = `LSTM_HID_DIM;
  localparam int DF   = `LSTM_DATA_FRAC;
  localparam int ONE  = `LSTM_ONE;
  localparam int SMAX = 32767;
  localparam int SMIN = -32768;

  lstm_pkg::sample_t  c_mem  [HID];  // cell state per unit
  lstm_pkg::sample_t  h_cur  [HID];  // committed h, feeds the recurrent terms
  lstm_pkg::sample_t  h_next [HID];  // h being built this step
  lstm_pkg::sample_t  c_old, c_new, c_tanh, h_new;
  logic signed [31:0] fc_p, ig_p, c_sum, h_p;
  logic               last_unit;

  //////////////////////////////////////////////////////////////////////
  // c and h for the unit at the input
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    c_old = c_mem[act_unit_i];
    fc_p  = gate_f_i * c_old;                // f * c_old
    ig_p  = gate_i_i * gate_g_i;             // i * g
    c_sum = (fc_p >>> DF) + (ig_p >>> DF);

    // saturate to 16 bits
    if (c_sum > SMAX)
      c_new = lstm_pkg::sample_t'(SMAX);
    else if (c_sum < SMIN)
      c_new = lstm_pkg::sample_t'(SMIN);
    else
      c_new = c_sum[15:0];

    // hard tanh of the new cell state
    if (c_new > ONE)
      c_tanh = lstm_pkg::sample_t'(ONE);
    else if (c_new < -ONE)
      c_tanh = lstm_pkg::sample_t'(-ONE);
    else
      c_tanh = c_new;

    h_p   = gate_o_i * c_tanh;
    h_new = h_p[DF +: 16];   // |h| <= 1.0, fits
  end

  assign last_unit = (act_unit_i == lstm_pkg::unit_idx_t'(HID - 1));

  always_ff @(posedge clk)
  begin
    if (!rst_n || clear_state_i)
    begin
      for (int k = 0; k < HID; k++)
      begin
        c_mem[k] <= '0;
        h_cur[k] <= '0;
      end
      dout_vld_o <= 1'b0;
      commit_o   <= 1'b0;
    end
    else
    begin
      dout_vld_o <= act_vld_i;
      commit_o   <= act_vld_i && last_unit;
      if (act_vld_i)
      begin
        c_mem[act_unit_i] <= c_new;
        // whole vector swaps in with the last unit
        if (last_unit)
        begin
          for (int k = 0; k < HID; k++)
          begin
            h_cur[k] <= (k == HID - 1) ? h_new : h_next[k];
          end
        end
      end
    end
  end

  // output word and staging buffer
  always_ff @(posedge clk)
  begin
    if (act_vld_i)
    begin
      h_next[act_unit_i] <= h_new;
      dout_idx_o         <= act_unit_i;
      dout_o             <= h_new;
    end
  end

  assign h_prev_o = h_cur;

endmodule

// ==== hw/lstm_weight_bank.sv ====
`include "lstm_config.svh"

module lstm_weight_bank (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      cfg_we_i,
  input  logic [`LSTM_ADDR_W-1:0]   cfg_addr_i,
  input  lstm_pkg::gate_row_t       cfg_wdata_i,
  input  logic [`LSTM_ADDR_W-1:0]   w_addr_i,
  input  lstm_pkg::unit_idx_t       b_unit_i,
  output lstm_pkg::gate_row_t       w_row_o,
  output lstm_pkg::gate_row_t       b_row_o
);

  localparam int AW        = `LSTM_ADDR_W;
  localparam int ROWS      = `LSTM_ROWS;
  localparam int BIAS_BASE = `LSTM_HID_DIM * `LSTM_TERMS;  // bias rows follow kernels

  lstm_pkg::gate_row_t mem [ROWS];
  logic [AW-1:0]       b_addr;
  logic                wr_ok;

  // writes to rows 36..63 are dropped
  assign wr_ok = cfg_we_i && (cfg_addr_i < AW'(ROWS));

  //////////////////////////////////////////////////////////////////////
  // register file
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int r = 0; r < ROWS; r++)
      begin
        mem[r] <= '0;
      end
    end
    else if (wr_ok)
    begin
      mem[cfg_addr_i] <= cfg_wdata_i;
    end
  end

  // bias row of the unit the mac is closing
  assign b_addr = AW'(BIAS_BASE) + AW'(b_unit_i);

  // async reads of one kernel row and one bias row
  assign w_row_o = mem[w_addr_i];
  assign b_row_o = mem[b_addr];

endmodule

// ==== lstm_cell_top.f ====
+incdir+hw
hw/lstm_pkg.sv
hw/lstm_weight_bank.sv
hw/lstm_sequencer.sv
hw/lstm_gate_mac.sv
hw/lstm_activation.sv
hw/lstm_state_update.sv
hw/lstm_cell_top.sv
testbench/tb_clock_gen.sv
testbench/lstm_cell_tb.sv

// ==== testbench/lstm_cell_tb.sv ====
`include "lstm_config.svh"

module lstm_cell_tb;

  localparam int HID       = `LSTM_HID_DIM;
  localparam int IN        = `LSTM_IN_DIM;
  localparam int ONE       = `LSTM_ONE;
  localparam int N_STEPS   = 30;    // 1 + 1 + 20 + 1 + 5 + 2
  localparam int STEP_CYC  = 200;
  localparam int MARGIN    = 1000;  // bank loads and spare
  localparam int PERIOD    = 100;

  logic                    clk, rst_n;
  logic                    cfg_we, clear_state, din_vld;
  logic [`LSTM_ADDR_W-1:0] cfg_addr;
  lstm_pkg::gate_row_t     cfg_wdata;
  lstm_pkg::sample_t       din;
  logic                    dout_vld, busy;
  lstm_pkg::unit_idx_t     dout_idx;
  lstm_pkg::sample_t       dout;

  lstm_pkg::gate_row_t w_mdl [`LSTM_ROWS];  // model copy of the bank
  int c_mdl [HID];
  int h_mdl [HID];
  int x_vec [IN];
  int exp_vec [HID];
  int got_vec [HID];
  int first_x [IN];  // kept for the replay after clear
  int first_h [HID];
  int out_idx_q [$];
  int out_val_q [$];
  int err_cnt, err_mark, tests_run, tests_failed;

  tb_clock_gen u_clk (.clk_o (clk), .rst_n_o (rst_n));

  lstm_cell_top dut_i (
    .clk, .rst_n, .cfg_we_i (cfg_we), .cfg_addr_i (cfg_addr), .cfg_wdata_i (cfg_wdata),
    .clear_state_i (clear_state), .din_vld_i (din_vld), .din_i (din),
    .dout_vld_o (dout_vld), .dout_idx_o (dout_idx), .dout_o (dout), .busy_o (busy)
  );

  //////////////////////////////////////////////////////////////////////
  // watchdog
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    #((N_STEPS * STEP_CYC + MARGIN) * PERIOD);
    $display("timeout: the DUT did not finish all steps in time");
    $display("=== FAIL ===");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers and reference model
  //////////////////////////////////////////////////////////////////////

  task automatic check(input int got, input int exp, input string msg);
    if (got !== exp)
    begin
      err_cnt++;
      $display("[ERROR] %0t: %s, got %0d expected %0d", $time, msg, got, exp);
    end
  endtask

  function automatic int clamp(input int v, input int lo, input int hi);
    return (v < lo) ? lo : (v > hi) ? hi : v;
  endfunction

  function automatic int rnd(input int span);  // -span/2 .. span/2-1
    return int'($urandom() % span) - span / 2;
  endfunction

  function automatic lstm_pkg::gate_row_t rnd_row(input int span);
    lstm_pkg::gate_row_t row;
    for (int g = 0; g < 4; g++)
      row[16*g +: 16] = 16'(rnd(span));
    return row;
  endfunction

  // one cell step with every unit on the old h
  task automatic model_step();
    logic signed [15:0] op, w, b;
    int acc, prod, pre, cs;
    int gate [4];
    int h_new [HID];
    for (int j = 0; j < HID; j++)
    begin
      for (int g = 0; g < 4; g++)
      begin
        acc = 0;
        for (int k = 0; k < `LSTM_TERMS; k++)
        begin
          op   = (k < IN) ? 16'(x_vec[k]) : 16'(h_mdl[k - IN]);
          w    = w_mdl[j * `LSTM_TERMS + k][16*(3-g) +: 16];  // i f c o from the top
          prod = op * w;
          acc  = (k == 0) ? prod : acc + prod;  // wraps mod 2^32
        end
        b   = w_mdl[HID * `LSTM_TERMS + j][16*(3-g) +: 16];
        pre = clamp((acc >>> `LSTM_W_FRAC) + int'(b), -131072, 131071);
        gate[g] = (g == 2) ? clamp(pre, -ONE, ONE)
                           : clamp((pre >>> 2) + ONE / 2, 0, ONE);
      end
      cs = ((gate[1] * c_mdl[j]) >>> `LSTM_DATA_FRAC) + ((gate[0] * gate[2]) >>> `LSTM_DATA_FRAC);
      c_mdl[j] = clamp(cs, -32768, 32767);
      h_new[j] = (gate[3] * clamp(c_mdl[j], -ONE, ONE)) >>> `LSTM_DATA_FRAC;
    end
    for (int j = 0; j < HID; j++)
    begin
      h_mdl[j]   = h_new[j];
      exp_vec[j] = h_new[j];
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus tasks driven on the falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic write_row(input int addr, input lstm_pkg::gate_row_t data);
    @(negedge clk);
    cfg_we    = 1'b1;
    cfg_addr  = addr[`LSTM_ADDR_W-1:0];
    cfg_wdata = data;
    @(negedge clk);
    cfg_we = 1'b0;
    if (addr < `LSTM_ROWS)
      w_mdl[addr] = data;  // unmapped rows dropped
  endtask

  task automatic load_bank(input int w_span, input int b_span);
    for (int r = 0; r < `LSTM_ROWS; r++)
      write_row(r, rnd_row((r < HID * `LSTM_TERMS) ? w_span : b_span));
  endtask

  task automatic clear_pulse();
    @(negedge clk);
    clear_state = 1'b1;
    @(negedge clk);
    clear_state = 1'b0;
    for (int j = 0; j < HID; j++)
    begin
      c_mdl[j] = 0;
      h_mdl[j] = 0;
    end
  endtask

  // four strobes then collect outputs until busy drops
  task automatic run_step(input int x_span, input bit replay);
    for (int k = 0; k < IN; k++)
      x_vec[k] = replay ? first_x[k] : rnd(x_span);
    model_step();
    out_idx_q.delete();
    out_val_q.delete();
    for (int k = 0; k < IN; k++)
    begin
      @(negedge clk);
      din_vld = 1'b1;
      din     = 16'(x_vec[k]);
    end
    @(negedge clk);
    din_vld = 1'b0;
    check(int'(busy), 1, "busy_o not high after the fourth strobe");
    while (busy)
    begin
      if (dout_vld)
      begin
        out_idx_q.push_back(int'(dout_idx));
        out_val_q.push_back(int'(dout));  // sign extended
      end
      @(negedge clk);
    end
    // busy drops one cycle after the unit 3 output
    check(int'(dout_vld), 0, "dout_vld_o after busy_o fell");
    check(out_idx_q.size(), HID, "outputs before busy_o fell");
    for (int j = 0; j < HID && j < out_idx_q.size(); j++)
    begin
      check(out_idx_q[j], j, "dout_idx_o order");
      check(out_val_q[j], exp_vec[j], $sformatf("h[%0d]", j));
      got_vec[j] = out_val_q[j];
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_cnt != err_mark)
    begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, err_cnt - err_mark);
    end
    else
      $display("test %s: ok", name);
    err_mark = err_cnt;
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    void'($urandom(32'h817cbfb8));
    cfg_we       = 1'b0;
    cfg_addr     = '0;
    cfg_wdata    = '0;
    clear_state  = 1'b0;
    din_vld      = 1'b0;
    din          = '0;
    err_cnt      = 0;
    err_mark     = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int r = 0; r < `LSTM_ROWS; r++)
      w_mdl[r] = '0;
    for (int j = 0; j < HID; j++)
    begin
      c_mdl[j] = 0;
      h_mdl[j] = 0;
    end

    @(posedge rst_n);
    @(negedge clk);
    check(int'(busy), 0, "busy_o after reset");
    check(int'(dout_vld), 0, "dout_vld_o after reset");
    load_bank(4096, 4096);  // +-0.25 weights and +-0.5 biases
    run_step(8192, 1'b0);
    first_x = x_vec;
    first_h = got_vec;
    end_test("1 reset and first step");

    run_step(8192, 1'b0);
    end_test("2 output order and busy");

    for (int s = 0; s < 20; s++)
      run_step(8192, 1'b0);
    end_test("3 random sequence");

    clear_pulse();
    run_step(8192, 1'b1);
    for (int j = 0; j < HID; j++)
      check(got_vec[j], first_h[j], $sformatf("replayed h[%0d]", j));
    end_test("4 clear and replay");

    load_bank(65536, 65536);  // full range drives the clamps
    clear_pulse();
    for (int s = 0; s < 5; s++)
      run_step(65536, 1'b0);
    end_test("5 saturation");

    for (int r = `LSTM_ROWS; r < (1 << `LSTM_ADDR_W); r++)
      write_row(r, rnd_row(65536));
    for (int s = 0; s < 2; s++)
      run_step(8192, 1'b0);
    end_test("6 unmapped writes");

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== testbench/tb_clock_gen.sv ====
module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF = 50;  // period 100

  initial
  begin
    clk_o = 1'b0;
    forever #HALF clk_o = ~clk_o;
  end

  // two cycles of reset, released on a falling edge
  initial
  begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule
